// File: dv/kr580_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_params.svh"

module kr580_tb import kr580_pkg::*; ();

    localparam int ROM_DEPTH = 1024;

    logic   pin_clk = 1'b0;
    logic   rst_n = 1'b0;
    data_t  pin_d;
    data_t  pin_pi;
    addr_t  pin_a;
    data_t  pin_pa;
    data_t  pin_po;
    logic   pin_pw;

    data_t       rom [ROM_DEPTH];
    data_t       m_reg [8];         // Model of B..A
    flags_t      m_f;
    logic [31:0] lfsr_q;
    int          prog_len = 0;
    int          cycles = 0;
    int          limit = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    // Expected port writes, in program order
    string       exp_name [$];
    data_t       exp_port [$];
    data_t       exp_data [$];
    flags_t      exp_mask [$];
    flags_t      exp_flags [$];

    always #50 pin_clk = ~pin_clk;

    assign pin_d  = (pin_a < ROM_DEPTH) ? rom[pin_a[9:0]] : 8'h76;
    assign pin_pi = ~pin_pa;        // Port model inverts the address

    kr580_top dut_i (
        .pin_clk  (pin_clk),
        .rst_n_i  (rst_n),
        .pin_d_i  (pin_d),
        .pin_a_o  (pin_a),
        .pin_pa_o (pin_pa),
        .pin_pi_i (pin_pi),
        .pin_po_o (pin_po),
        .pin_pw_o (pin_pw)
    );

    // --------------------
    // Stimulus helpers
    // --------------------
    function automatic logic [7:0] draw_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            v[i] = lfsr_q[0];
        end
        return v;
    endfunction

    // Expected {flags, result} of one accumulator operation
    function automatic logic [15:0] kr580_ref_alu(input alu_op_t op, input data_t a,
                                                  input data_t b, input logic carry);
        int     c;
        int     r;
        int     sv;
        int     sa;
        int     sb;
        data_t  res;
        flags_t f;
        logic   sub_op;
        c      = ((op == ALU_ADC) || (op == ALU_SBC)) ? (carry ? 1 : 0) : 0;
        sub_op = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
        sa     = a[7] ? int'(a) - 256 : int'(a);
        sb     = b[7] ? int'(b) - 256 : int'(b);
        sv     = sub_op ? sa - sb - c : sa + sb + c;    // Signed view for overflow
        case (op)
            ALU_AND: r = a & b;
            ALU_XOR: r = a ^ b;
            ALU_OR:  r = a | b;
            default: r = sub_op ? int'(a) - int'(b) - c : int'(a) + int'(b) + c;
        endcase
        res = r[7:0];
        f = '0;
        f[`KR_FLAG_SIGN] = res[7];
        f[`KR_FLAG_ZERO] = (res == 8'h00);
        if ((op == ALU_AND) || (op == ALU_XOR) || (op == ALU_OR)) begin
            f[`KR_FLAG_PARITY] = ~^res;
        end else begin
            if (sub_op) begin
                f[`KR_FLAG_CARRY] = (int'(a) < int'(b) + c);
                f[`KR_FLAG_AUX]   = (int'(a[3:0]) < int'(b[3:0]) + c);
            end else begin
                f[`KR_FLAG_CARRY] = (r > 255);
                f[`KR_FLAG_AUX]   = (int'(a[3:0]) + int'(b[3:0]) + c > 15);
            end
            f[`KR_FLAG_NEG]    = sub_op;
            f[`KR_FLAG_PARITY] = (op == ALU_CP) ? ~^res : ((sv > 127) || (sv < -128));
        end
        return {f, res};
    endfunction

    task automatic emit_byte(input data_t b);
        rom[prog_len] = b;
        prog_len++;
    endtask

    task automatic load_imm(input reg_sel_t r, input data_t v);
        emit_byte({2'b00, r, 3'b110});
        emit_byte(v);
        m_reg[r] = v;
    endtask

    task automatic copy_reg(input reg_sel_t dst, input reg_sel_t src);
        emit_byte({2'b01, dst, src});
        m_reg[dst] = m_reg[src];
    endtask

    task automatic track_alu(input alu_op_t op, input data_t b);
        logic [15:0] ref_v;
        ref_v = kr580_ref_alu(op, m_reg[`KR_REG_A], b, m_f[`KR_FLAG_CARRY]);
        if (op != ALU_CP) begin
            m_reg[`KR_REG_A] = ref_v[7:0];
        end
        m_f = ref_v[15:8];
    endtask

    task automatic alu_on_reg(input alu_op_t op, input reg_sel_t r);
        emit_byte({2'b10, op, r});
        track_alu(op, m_reg[r]);
    endtask

    task automatic alu_on_imm(input alu_op_t op, input data_t v);
        emit_byte({2'b11, op, 3'b110});
        emit_byte(v);
        track_alu(op, v);
    endtask

    task automatic jump(input data_t opcode, input addr_t target);
        emit_byte(opcode);
        emit_byte(target[7:0]);
        emit_byte(target[15:8]);
    endtask

    task automatic read_port(input data_t port);
        emit_byte(8'hDB);
        emit_byte(port);
        m_reg[`KR_REG_A] = ~port;
    endtask

    task automatic write_port(input data_t port, input string name, input flags_t mask);
        emit_byte(8'hD3);
        emit_byte(port);
        exp_name.push_back(name);
        exp_port.push_back(port);
        exp_data.push_back(m_reg[`KR_REG_A]);
        exp_mask.push_back(mask);
        exp_flags.push_back(m_f & mask);
    endtask

    // JP cc over two marker loads, bit 0 of the marker shows the tested flag
    task automatic branch_on(input cond_t c, input data_t base, input string name);
        addr_t p;
        int    pos;
        case (c[2:1])
            2'd0:    pos = `KR_FLAG_ZERO;
            2'd1:    pos = `KR_FLAG_CARRY;
            2'd2:    pos = `KR_FLAG_PARITY;
            default: pos = `KR_FLAG_SIGN;
        endcase
        p = addr_t'(prog_len);
        jump({2'b11, c, 3'b010}, p + 16'd8);
        load_imm(`KR_REG_A, base | {7'd0, ~c[0]});     // Not taken
        jump(8'hC3, p + 16'd10);
        load_imm(`KR_REG_A, base | {7'd0, c[0]});      // Taken
        m_reg[`KR_REG_A] = base | {7'd0, m_f[pos]};
        write_port(8'h60, name, flags_t'(1 << pos));
    endtask

    task automatic build_program();
        data_t    a;
        reg_sel_t r;
        addr_t    p;
        load_imm(`KR_REG_B, draw_bits(8));
        copy_reg(`KR_REG_A, `KR_REG_B);
        write_port(draw_bits(8), "ld_move", 8'h00);
        for (int k = 0; k < 8; k++) begin
            r = reg_sel_t'(draw_bits(8) % 6);
            load_imm(`KR_REG_A, draw_bits(8));
            load_imm(r, draw_bits(8));
            alu_on_reg(alu_op_t'(k), r);
            write_port(8'h20, $sformatf("alu_reg_op%0d", k), 8'h00);
            load_imm(`KR_REG_A, draw_bits(8));
            alu_on_imm(alu_op_t'(k), draw_bits(8));
            write_port(8'h21, $sformatf("alu_imm_op%0d", k), 8'h00);
        end
        for (int k = 0; k < 16; k++) begin
            a = draw_bits(8);
            load_imm(`KR_REG_A, a);
            if (k < 8) begin
                alu_on_imm(alu_op_t'(draw_bits(3)), draw_bits(8));
            end else begin
                alu_on_imm(ALU_SUB, a);     // Zero result
            end
            branch_on(cond_t'(k % 8), data_t'(k << 4), $sformatf("cond%0d_run%0d", k % 8, k / 8));
        end
        // Carry chains, operands force carry and borrow
        load_imm(`KR_REG_A, draw_bits(8) | 8'h80);
        alu_on_imm(ALU_ADD, draw_bits(8) | 8'h80);
        alu_on_imm(ALU_ADC, draw_bits(8));
        write_port(8'h30, "add_adc", 8'h00);
        load_imm(`KR_REG_A, draw_bits(8) & 8'h7f);
        alu_on_imm(ALU_SUB, draw_bits(8) | 8'h80);
        alu_on_imm(ALU_SBC, draw_bits(8));
        write_port(8'h31, "sub_sbc", 8'h00);
        read_port(draw_bits(8));
        write_port(8'h40, "in_port", 8'h00);
        p = addr_t'(prog_len);
        jump(8'hC3, p + 16'd5);
        emit_byte(8'hD3);       // Skipped OUT
        emit_byte(8'h50);
        load_imm(`KR_REG_A, 8'h5a);
        write_port(8'h51, "jp_skip", 8'h00);
        emit_byte(8'h76);       // HALT
        emit_byte(8'hD3);
        emit_byte(8'h52);
    endtask

    // --------------------
    // Checking
    // --------------------
    task automatic check_byte(input string name, input data_t exp, input data_t act);
        if (exp === act) begin
            pass_count++;
            $display("[PASS] %s %02h", name, act);
        end else begin
            fail_count++;
            $display("[FAIL] %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp === act) begin
            pass_count++;
            $display("[PASS] %s %04h", name, act);
        end else begin
            fail_count++;
            $display("[FAIL] %s expected %04h actual %04h", name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input flags_t exp, input flags_t act);
        if (exp === act) begin
            pass_count++;
            $display("[PASS] %s %08b", name, act);
        end else begin
            fail_count++;
            $display("[FAIL] %s expected %08b actual %08b", name, exp, act);
        end
    endtask

    always @(negedge pin_clk) begin : port_monitor
        string  name;
        flags_t mask;
        flags_t want_f;
        if (rst_n && pin_pw) begin
            if (exp_name.size() == 0) begin
                fail_count++;
                $display("Unexpected port write of %02h to port %02h", pin_po, pin_pa);
            end else begin
                name   = exp_name.pop_front();
                mask   = exp_mask.pop_front();
                want_f = exp_flags.pop_front();
                check_byte({name, " port"}, exp_port.pop_front(), pin_pa);
                check_byte(name, exp_data.pop_front(), pin_po);
                if (mask != 8'h00) begin
                    check_flags({name, " flags"}, want_f, pin_po[0] ? mask : 8'h00);
                end
            end
        end
    end

    initial begin
        rst_n  = 1'b0;
        lfsr_q = 32'h5dd0e32d;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = 8'h76;     // HALT stops a stray jump
        end
        for (int i = 0; i < 8; i++) begin
            m_reg[i] = 8'h00;
        end
        m_f = `KR_FLAGS_RESET;
        build_program();
        limit = 4 * prog_len + 64;
        repeat (8) @(posedge pin_clk);
        #1;
        // Pins while the core is held in reset
        check_addr("reset_addr", 16'h0000, pin_a);
        check_byte("reset_port", 8'h00, pin_pa);
        check_byte("reset_data", 8'h00, pin_po);
        if (pin_pw === 1'b0) begin
            pass_count++;
            $display("[PASS] reset_strobe %0b", pin_pw);
        end else begin
            fail_count++;
            $display("Port write strobe was not low during reset");
        end
        rst_n = 1'b1;
        while ((exp_name.size() != 0) && (cycles < limit)) begin
            @(posedge pin_clk);
            cycles++;
        end
        if (exp_name.size() != 0) begin
            fail_count++;
            $display("Run timed out before the expected port writes arrived");
        end
        // Halted core must stay quiet for the rest of the window
        while (cycles < limit) begin
            @(posedge pin_clk);
            cycles++;
        end
        $display("Checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/kr580_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_params.svh"

module kr580_alu import kr580_pkg::*; (
    input  wire alu_op_t op_i,
    input  wire data_t   a_i,
    input  wire data_t   b_i,
    input  wire logic    carry_i,
    output data_t        res_o,
    output flags_t       res_flags_o
);

    logic [8:0] sum;        // Bit 8 is carry or borrow
    logic [4:0] half;       // Low nibble, bit 4 is aux
    logic       cin;
    logic       sub;
    logic       is_logic;
    logic       ovf;

    always_comb begin
        cin      = (op_i == ALU_ADC || op_i == ALU_SBC) ? carry_i : 1'b0;
        sub      = (op_i == ALU_SUB) || (op_i == ALU_SBC) || (op_i == ALU_CP);
        is_logic = (op_i == ALU_AND) || (op_i == ALU_XOR) || (op_i == ALU_OR);

        sum  = '0;
        half = '0;
        case (op_i)
            ALU_ADD, ALU_ADC: begin
                sum  = {1'b0, a_i} + {1'b0, b_i} + {8'd0, cin};
                half = {1'b0, a_i[3:0]} + {1'b0, b_i[3:0]} + {4'd0, cin};
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                sum  = {1'b0, a_i} - {1'b0, b_i} - {8'd0, cin};
                half = {1'b0, a_i[3:0]} - {1'b0, b_i[3:0]} - {4'd0, cin};
            end
            ALU_AND: sum = {1'b0, a_i & b_i};
            ALU_XOR: sum = {1'b0, a_i ^ b_i};
            ALU_OR:  sum = {1'b0, a_i | b_i};
            default: sum = '0;
        endcase

        // Signed overflow, operands alike for add, unlike for subtract
        if (sub) begin
            ovf = (a_i[7] != b_i[7]) && (a_i[7] != sum[7]);
        end else begin
            ovf = (a_i[7] == b_i[7]) && (a_i[7] != sum[7]);
        end
    end

    // --------------------
    // Flag byte
    // --------------------
    always_comb begin
        res_o       = sum[7:0];
        res_flags_o = '0;   // Bits 3 and 5 stay clear

        res_flags_o[`KR_FLAG_SIGN] = sum[7];
        res_flags_o[`KR_FLAG_ZERO] = (sum[7:0] == 8'h00);

        if (is_logic) begin
            res_flags_o[`KR_FLAG_PARITY] = ~^sum[7:0];     // Even parity
        end else begin
            res_flags_o[`KR_FLAG_CARRY]  = sum[8];
            res_flags_o[`KR_FLAG_AUX]    = half[4];
            res_flags_o[`KR_FLAG_NEG]    = sub;
            // CP reports parity like the logic group
            res_flags_o[`KR_FLAG_PARITY] = (op_i == ALU_CP) ? ~^sum[7:0] : ovf;
        end
    end

endmodule

`default_nettype wire

// File: src/kr580_params.svh
`ifndef KR580_PARAMS_SVH
`define KR580_PARAMS_SVH

// --------------------
// Bus widths
// --------------------
`define KR_DATA_W       8
`define KR_ADDR_W       16

// Flag byte layout, SZ-A-P-NC
`define KR_FLAG_CARRY   0
`define KR_FLAG_NEG     1
`define KR_FLAG_PARITY  2
`define KR_FLAG_AUX     4
`define KR_FLAG_ZERO    6
`define KR_FLAG_SIGN    7

// --------------------
// Register codes
// --------------------
`define KR_REG_B        3'd0
`define KR_REG_C        3'd1
`define KR_REG_D        3'd2
`define KR_REG_E        3'd3
`define KR_REG_H        3'd4
`define KR_REG_L        3'd5
`define KR_REG_F        3'd6    // Slot of the flag byte
`define KR_REG_A        3'd7

`define KR_FLAGS_RESET  8'h40   // Zero set only

`endif

// File: src/kr580_pkg.sv
`default_nettype none

`include "kr580_params.svh"

package kr580_pkg;

    typedef logic [`KR_DATA_W-1:0] data_t;
    typedef logic [`KR_ADDR_W-1:0] addr_t;
    typedef logic [7:0]            flags_t;
    typedef logic [2:0]            reg_sel_t;
    typedef logic [2:0]            cond_t;     // NZ Z NC C PO PE P M

    // Codes match opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        STEP_FETCH,
        STEP_OPER1,
        STEP_OPER2,
        STEP_EXEC,
        STEP_HALT
    } seq_step_t;

endpackage

`default_nettype wire

// File: src/kr580_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_params.svh"

module kr580_regfile import kr580_pkg::*; (
    input  wire            pin_clk,
    input  wire            rst_n_i,
    input  wire reg_sel_t  rd_sel_i,
    output data_t          rd_data_o,
    input  wire            wr_en_i,
    input  wire reg_sel_t  wr_sel_i,
    input  wire data_t     wr_data_i,
    input  wire            flag_we_i,
    input  wire flags_t    flag_data_i,
    output data_t          acc_o,
    output flags_t         flags_o
);

    // B C D E H L F A, F lives in the (HL) slot
    data_t regs_q [8];

    always_ff @(posedge pin_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
            regs_q[`KR_REG_F] <= `KR_FLAGS_RESET;
        end else begin
            // Byte writes never land on F
            if (wr_en_i && (wr_sel_i != `KR_REG_F)) begin
                regs_q[wr_sel_i] <= wr_data_i;
            end
            if (flag_we_i) begin
                regs_q[`KR_REG_F] <= flag_data_i;
            end
        end
    end

    // --------------------
    // Read side
    // --------------------
    assign rd_data_o = regs_q[rd_sel_i];    // Code 6 gives F
    assign acc_o     = regs_q[`KR_REG_A];
    assign flags_o   = regs_q[`KR_REG_F];

endmodule

`default_nettype wire

// File: src/kr580_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_params.svh"

module kr580_sequencer import kr580_pkg::*; (
    input  wire            pin_clk,
    input  wire            rst_n_i,
    input  wire data_t     pin_d_i,
    input  wire data_t     pin_pi_i,
    output addr_t          pin_a_o,
    output data_t          pin_pa_o,
    output data_t          pin_po_o,
    output logic           pin_pw_o,
    output reg_sel_t       rd_sel_o,
    input  wire data_t     rd_data_i,
    input  wire data_t     acc_i,
    input  wire flags_t    flags_i,
    output alu_op_t        alu_op_o,
    output data_t          alu_b_o,
    input  wire data_t     alu_res_i,
    input  wire flags_t    alu_flags_i,
    output logic           wr_en_o,
    output reg_sel_t       wr_sel_o,
    output data_t          wr_data_o,
    output logic           flag_we_o
);

    seq_step_t step_q;
    addr_t     pc_q;
    data_t     opcode_q;
    data_t     lo_q;        // Immediate or low byte of jump target
    data_t     cur_op;

    logic      is_ld_imm;
    logic      is_ld_rr;
    logic      is_alu_r;
    logic      is_alu_i;
    logic      is_jp;
    logic      is_out;
    logic      is_in;
    logic      is_halt;
    logic      has_oper;
    logic      exec;

    cond_t     cond;
    logic      flag_bit;
    logic      jp_taken;

    // Opcode is still on the bus during fetch
    assign cur_op = (step_q == STEP_FETCH) ? pin_d_i : opcode_q;

    // --------------------
    // Decode
    // --------------------
    always_comb begin
        is_ld_imm = 1'b0;
        is_ld_rr  = 1'b0;
        is_alu_r  = 1'b0;
        is_alu_i  = 1'b0;
        is_jp     = 1'b0;
        is_out    = 1'b0;
        is_in     = 1'b0;
        is_halt   = 1'b0;
        casez (cur_op)
            8'b00_???_110:              is_ld_imm = 1'b1;
            8'b01_110_110:              is_halt   = 1'b1;   // Ahead of LD r,r
            8'b01_???_???:              is_ld_rr  = 1'b1;
            8'b10_???_???:              is_alu_r  = 1'b1;
            8'b11_???_110:              is_alu_i  = 1'b1;
            8'b11_000_011, 8'b11_???_010: is_jp   = 1'b1;
            8'b11_010_011:              is_out    = 1'b1;
            8'b11_011_011:              is_in     = 1'b1;
            default: ;                                  // NOP and the rest
        endcase
        has_oper = is_ld_imm | is_alu_i | is_jp | is_out | is_in;
    end

    // Condition test, JP nn has opcode bit 0 set
    always_comb begin
        cond = cond_t'(cur_op[5:3]);
        case (cond[2:1])
            2'd0:    flag_bit = flags_i[`KR_FLAG_ZERO];
            2'd1:    flag_bit = flags_i[`KR_FLAG_CARRY];
            2'd2:    flag_bit = flags_i[`KR_FLAG_PARITY];
            default: flag_bit = flags_i[`KR_FLAG_SIGN];
        endcase
        jp_taken = cur_op[0] | (flag_bit == cond[0]);
    end

    // --------------------
    // Step machine
    // --------------------
    always_ff @(posedge pin_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            step_q   <= STEP_FETCH;
            pc_q     <= '0;
            opcode_q <= '0;
            pin_pa_o <= '0;
            pin_po_o <= '0;
            pin_pw_o <= 1'b0;
        end else begin
            pin_pw_o <= 1'b0;     // Single cycle strobe
            case (step_q)
                STEP_FETCH: begin
                    opcode_q <= pin_d_i;
                    pc_q     <= pc_q + 1'b1;
                    if (is_halt) begin
                        step_q <= STEP_HALT;
                    end else if (has_oper) begin
                        step_q <= STEP_OPER1;
                    end else begin
                        step_q <= STEP_EXEC;
                    end
                end
                STEP_OPER1: begin
                    pc_q <= pc_q + 1'b1;
                    if (is_out || is_in) begin
                        pin_pa_o <= pin_d_i;    // Port number
                    end
                    if (is_out) begin
                        pin_po_o <= acc_i;
                        pin_pw_o <= 1'b1;
                    end
                    step_q <= is_jp ? STEP_OPER2 : STEP_EXEC;
                end
                STEP_OPER2: begin
                    // High byte of the target is on the bus now
                    pc_q   <= jp_taken ? {pin_d_i, lo_q} : pc_q + 1'b1;
                    step_q <= STEP_EXEC;
                end
                STEP_EXEC: step_q <= STEP_FETCH;
                default:   step_q <= STEP_HALT;  // Only reset leaves HALT
            endcase
        end
    end

    always_ff @(posedge pin_clk) begin
        if (step_q == STEP_OPER1) begin
            lo_q <= pin_d_i;
        end
    end

    // --------------------
    // Writeback
    // --------------------
    assign exec     = (step_q == STEP_EXEC);
    assign pin_a_o  = pc_q;
    assign rd_sel_o = reg_sel_t'(opcode_q[2:0]);
    assign alu_op_o = alu_op_t'(opcode_q[5:3]);
    assign alu_b_o  = is_alu_i ? lo_q : rd_data_i;

    always_comb begin
        wr_en_o = exec & (is_ld_imm | is_ld_rr | is_in |
                          ((is_alu_r | is_alu_i) & (alu_op_o != ALU_CP)));
        wr_sel_o = (is_ld_imm | is_ld_rr) ? reg_sel_t'(opcode_q[5:3]) : `KR_REG_A;

        if (is_ld_imm) begin
            wr_data_o = lo_q;
        end else if (is_ld_rr) begin
            wr_data_o = rd_data_i;    // Source register
        end else if (is_in) begin
            wr_data_o = pin_pi_i;
        end else begin
            wr_data_o = alu_res_i;
        end

        // Every accumulator operation updates F
        flag_we_o = exec & (is_alu_r | is_alu_i);
    end

endmodule

`default_nettype wire

// File: src/kr580_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "kr580_params.svh"

module kr580_top import kr580_pkg::*; (
    input  wire         pin_clk,
    input  wire         rst_n_i,
    input  wire data_t  pin_d_i,
    output addr_t       pin_a_o,
    output data_t       pin_pa_o,
    input  wire data_t  pin_pi_i,
    output data_t       pin_po_o,
    output logic        pin_pw_o
);

    reg_sel_t rd_sel;
    data_t    rd_data;
    data_t    acc;
    flags_t   flags;
    alu_op_t  alu_op;
    data_t    alu_b;
    data_t    alu_res;
    flags_t   alu_flags;    // Straight into F
    logic     wr_en;
    reg_sel_t wr_sel;
    data_t    wr_data;
    logic     flag_we;

    kr580_sequencer u_seq (
        .pin_clk     (pin_clk),
        .rst_n_i     (rst_n_i),
        .pin_d_i     (pin_d_i),
        .pin_pi_i    (pin_pi_i),
        .pin_a_o     (pin_a_o),
        .pin_pa_o    (pin_pa_o),
        .pin_po_o    (pin_po_o),
        .pin_pw_o    (pin_pw_o),
        .rd_sel_o    (rd_sel),
        .rd_data_i   (rd_data),
        .acc_i       (acc),
        .flags_i     (flags),
        .alu_op_o    (alu_op),
        .alu_b_o     (alu_b),
        .alu_res_i   (alu_res),
        .alu_flags_i (alu_flags),
        .wr_en_o     (wr_en),
        .wr_sel_o    (wr_sel),
        .wr_data_o   (wr_data),
        .flag_we_o   (flag_we)
    );

    kr580_alu u_alu (
        .op_i        (alu_op),
        .a_i         (acc),
        .b_i         (alu_b),
        .carry_i     (flags[`KR_FLAG_CARRY]),
        .res_o       (alu_res),
        .res_flags_o (alu_flags)
    );

    kr580_regfile u_regs (
        .pin_clk     (pin_clk),
        .rst_n_i     (rst_n_i),
        .rd_sel_i    (rd_sel),
        .rd_data_o   (rd_data),
        .wr_en_i     (wr_en),
        .wr_sel_i    (wr_sel),
        .wr_data_i   (wr_data),
        .flag_we_i   (flag_we),
        .flag_data_i (alu_flags),
        .acc_o       (acc),
        .flags_o     (flags)
    );

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/kr580_pkg.sv
src/kr580_alu.sv
src/kr580_regfile.sv
src/kr580_sequencer.sv
src/kr580_top.sv
dv/kr580_tb.sv
